// ==== hw/br_rs_pkg.sv ====
package br_rs_pkg;

    localparam int RS_DEPTH         = 16;
    localparam int PTR_W            = $clog2(RS_DEPTH) + 1; // extra wrap bit
    localparam int TAG_W            = 8;
    localparam int XLEN             = 32;
    localparam int NUM_RESULT_BUSES = 5;

    // writeback buses, lowest index wins on a tag collision
    localparam int BUS_ALU  = 0;
    localparam int BUS_MUL  = 1;
    localparam int BUS_DIV  = 2;
    localparam int BUS_LOAD = 3;
    localparam int BUS_BR   = 4; // branch link result

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             ready;
        logic [XLEN-1:0]  data;
    } operand_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [XLEN-1:0]  data;
    } result_bus_t;

    typedef struct packed {
        logic [XLEN-1:0]  inst_num;
        logic [XLEN-1:0]  pc;
        logic [TAG_W-1:0] rd;
        logic             jump;
        logic             branch;
        logic [2:0]       funct3;
        logic [XLEN-1:0]  imm;
        logic             pred_taken;
        logic             pred_hit;
        operand_t         src1;
        operand_t         src2;
    } rs_entry_t;

    // what the branch unit gets, operands already resolved to data
    typedef struct packed {
        logic [XLEN-1:0]  inst_num;
        logic [XLEN-1:0]  pc;
        logic [TAG_W-1:0] rd;
        logic             jump;
        logic             branch;
        logic [2:0]       funct3;
        logic [XLEN-1:0]  imm;
        logic             pred_taken;
        logic             pred_hit;
        logic [XLEN-1:0]  op1;
        logic [XLEN-1:0]  op2;
    } issue_t;

endpackage

// ==== hw/br_rs_wakeup.sv ====
`timescale 1ns/100ps

module br_rs_wakeup (
    input  br_rs_pkg::operand_t    in,
    input  br_rs_pkg::result_bus_t result_buses [br_rs_pkg::NUM_RESULT_BUSES],
    output br_rs_pkg::operand_t    out
);

    import br_rs_pkg::*;

    logic [NUM_RESULT_BUSES-1:0] hit;

    // per-bus tag compare
    always_comb begin
        for (int i = 0; i < NUM_RESULT_BUSES; i++) begin
            hit[i] = result_buses[i].valid && (result_buses[i].tag == in.tag);
        end
    end

    // walk from the lowest priority bus up, so ALU lands last and wins
    always_comb begin
        out = in;
        if (!in.ready) begin
            for (int i = NUM_RESULT_BUSES - 1; i >= BUS_ALU; i--) begin
                if (hit[i]) begin
                    out.ready = 1'b1;
                    out.data  = result_buses[i].data;
                end
            end
        end
    end

endmodule

// ==== hw/br_rs_dispatch.sv ====
`timescale 1ns/100ps

module br_rs_dispatch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   dispatch_valid,
    input  br_rs_pkg::rs_entry_t   dispatch_entry,
    input  br_rs_pkg::result_bus_t result_buses [br_rs_pkg::NUM_RESULT_BUSES],
    output logic                   stage_valid,
    output br_rs_pkg::rs_entry_t   stage_entry
);

    import br_rs_pkg::*;

    operand_t  src1_woken;
    operand_t  src2_woken;
    rs_entry_t entry_woken;

    // catch results broadcast in the dispatch cycle itself
    br_rs_wakeup i_wake_src1 (
        .in           (dispatch_entry.src1),
        .result_buses (result_buses),
        .out          (src1_woken)
    );

    br_rs_wakeup i_wake_src2 (
        .in           (dispatch_entry.src2),
        .result_buses (result_buses),
        .out          (src2_woken)
    );

    always_comb begin
        entry_woken      = dispatch_entry;
        entry_woken.src1 = src1_woken;
        entry_woken.src2 = src2_woken;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            stage_valid <= 1'b0; // flush drops the staged instr too
        end else begin
            stage_valid <= dispatch_valid;
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            stage_entry <= entry_woken;
        end
    end

    // operands that came in ready keep their dispatched data
    a_ready_src_kept: assert property (
        @(posedge clk) disable iff (rst || flush)
        dispatch_valid |=>
            (!$past(dispatch_entry.src1.ready) ||
             stage_entry.src1.data == $past(dispatch_entry.src1.data)) &&
            (!$past(dispatch_entry.src2.ready) ||
             stage_entry.src2.data == $past(dispatch_entry.src2.data))
    );

endmodule

// ==== hw/br_rs_queue.sv ====
`timescale 1ns/100ps

module br_rs_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   stage_valid,
    input  br_rs_pkg::rs_entry_t   stage_entry,
    input  br_rs_pkg::result_bus_t result_buses [br_rs_pkg::NUM_RESULT_BUSES],
    output logic                   issue_valid,
    output br_rs_pkg::issue_t      issue_pkt
);

    import br_rs_pkg::*;

    rs_entry_t entries [RS_DEPTH];
    logic [RS_DEPTH-1:0] entry_valid;

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-2:0] head_idx;
    logic [PTR_W-2:0] tail_idx;
    logic             queue_full;

    operand_t  src1_woken [RS_DEPTH];
    operand_t  src2_woken [RS_DEPTH];
    operand_t  in_src1_woken;
    operand_t  in_src2_woken;
    rs_entry_t in_entry;

    rs_entry_t head_entry;
    logic      head_src_ready;
    logic      issue_fire;
    issue_t    head_pkt;

    assign head_idx   = head[PTR_W-2:0];
    assign tail_idx   = tail[PTR_W-2:0];
    assign queue_full = ({~head[PTR_W-1], head[PTR_W-2:0]} == tail); // same slot on the next lap

    // wakeup for every stored source
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        br_rs_wakeup i_wake_src1 (
            .in           (entries[i].src1),
            .result_buses (result_buses),
            .out          (src1_woken[i])
        );

        br_rs_wakeup i_wake_src2 (
            .in           (entries[i].src2),
            .result_buses (result_buses),
            .out          (src2_woken[i])
        );
    end

    // the entry being written also sees this cycle's buses
    br_rs_wakeup i_wake_in_src1 (
        .in           (stage_entry.src1),
        .result_buses (result_buses),
        .out          (in_src1_woken)
    );

    br_rs_wakeup i_wake_in_src2 (
        .in           (stage_entry.src2),
        .result_buses (result_buses),
        .out          (in_src2_woken)
    );

    always_comb begin
        in_entry      = stage_entry;
        in_entry.src1 = in_src1_woken;
        in_entry.src2 = in_src2_woken;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            entries[i].src1 <= src1_woken[i];
            entries[i].src2 <= src2_woken[i];
        end
        if (stage_valid) begin
            entries[tail_idx] <= in_entry; // overrides the refresh above
        end
    end

    assign head_entry     = entries[head_idx];
    assign head_src_ready = head_entry.src1.ready && head_entry.src2.ready;
    assign issue_fire     = entry_valid[head_idx] && head_src_ready;

    always_comb begin
        head_pkt.inst_num   = head_entry.inst_num;
        head_pkt.pc         = head_entry.pc;
        head_pkt.rd         = head_entry.rd;
        head_pkt.jump       = head_entry.jump;
        head_pkt.branch     = head_entry.branch;
        head_pkt.funct3     = head_entry.funct3;
        head_pkt.imm        = head_entry.imm;
        head_pkt.pred_taken = head_entry.pred_taken;
        head_pkt.pred_hit   = head_entry.pred_hit;
        head_pkt.op1        = head_entry.src1.data;
        head_pkt.op2        = head_entry.src2.data;
    end

    // only pointers and valid bits clear on flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
        end else begin
            if (stage_valid) begin
                entry_valid[tail_idx] <= 1'b1;
                tail                  <= tail + 1'b1;
            end
            if (issue_fire) begin
                entry_valid[head_idx] <= 1'b0;
                head                  <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            issue_valid <= 1'b0;
            issue_pkt   <= '0;
        end else if (issue_fire) begin
            issue_valid <= 1'b1;
            issue_pkt   <= head_pkt;
        end else begin
            issue_valid <= 1'b0;
            issue_pkt   <= '0; // idle bus reads as zero
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst || flush)
        stage_valid |-> !queue_full
    );

    // emptied queue has nothing left that could fire
    a_quiet_after_clear: assert property (
        @(posedge clk) (rst || flush) |=> !issue_valid && !issue_fire
    );

    a_issue_from_ready: assert property (
        @(posedge clk) disable iff (rst)
        issue_valid |-> $past(entry_valid[head_idx] && head_src_ready)
    );

endmodule

// ==== hw/br_rs_top.sv ====
`timescale 1ns/100ps

module br_rs_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush,
    input  logic                   dispatch_valid,
    input  br_rs_pkg::rs_entry_t   dispatch_entry,
    input  br_rs_pkg::result_bus_t result_buses [br_rs_pkg::NUM_RESULT_BUSES],
    output logic                   issue_valid,
    output br_rs_pkg::issue_t      issue_pkt
);

    import br_rs_pkg::*;

    logic      stage_valid;
    rs_entry_t stage_entry;

    // stage 1, bypass capture and register
    br_rs_dispatch i_dispatch (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .result_buses   (result_buses),
        .stage_valid    (stage_valid),
        .stage_entry    (stage_entry)
    );

    // stage 2, in-order queue and issue register
    br_rs_queue i_queue (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .stage_valid  (stage_valid),
        .stage_entry  (stage_entry),
        .result_buses (result_buses),
        .issue_valid  (issue_valid),
        .issue_pkt    (issue_pkt)
    );

endmodule

// ==== tests/br_rs_cases.svh ====
`ifndef BR_RS_CASES_SVH
`define BR_RS_CASES_SVH

localparam int NUM_STEPS = 49;

// test, disp, inst, src1 tag, src1 ready, src2 tag, src2 ready, bus mask, bus tag,
// flush, expect issue, check latency, op1 row offset and bus, op2 row offset and bus
localparam step_t STEPS [NUM_STEPS] = '{
    '{0, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{0, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{0, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    // back to back, both operands ready
    '{1, 1,  1, 'h00, 1, 'h00, 1, 5'b00000, 'h00, 0, 1, 1, 0, DISP,     0, DISP},
    '{1, 1,  2, 'h00, 1, 'h00, 1, 5'b00000, 'h00, 0, 1, 1, 0, DISP,     0, DISP},
    '{1, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{1, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{1, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    // one waiter per bus, woken in order
    '{2, 1,  3, 'h21, 0, 'h00, 1, 5'b00000, 'h00, 0, 1, 0, 5, BUS_ALU,  0, DISP},
    '{2, 1,  4, 'h22, 0, 'h00, 1, 5'b00000, 'h00, 0, 1, 0, 5, BUS_MUL,  0, DISP},
    '{2, 1,  5, 'h00, 1, 'h23, 0, 5'b00000, 'h00, 0, 1, 0, 0, DISP,     5, BUS_DIV},
    '{2, 1,  6, 'h24, 0, 'h00, 1, 5'b00000, 'h00, 0, 1, 0, 5, BUS_LOAD, 0, DISP},
    '{2, 1,  7, 'h25, 0, 'h00, 1, 5'b00000, 'h00, 0, 1, 0, 5, BUS_BR,   0, DISP},
    '{2, 0,  0, 'h00, 0, 'h00, 0, 5'b00001, 'h21, 0, 0, 0, 0, DISP,     0, DISP},
    '{2, 0,  0, 'h00, 0, 'h00, 0, 5'b00010, 'h22, 0, 0, 0, 0, DISP,     0, DISP},
    '{2, 0,  0, 'h00, 0, 'h00, 0, 5'b00100, 'h23, 0, 0, 0, 0, DISP,     0, DISP},
    '{2, 0,  0, 'h00, 0, 'h00, 0, 5'b01000, 'h24, 0, 0, 0, 0, DISP,     0, DISP},
    '{2, 0,  0, 'h00, 0, 'h00, 0, 5'b10000, 'h25, 0, 0, 0, 0, DISP,     0, DISP},
    '{2, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{2, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{2, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    // result in the strobe cycle, then in the queue write cycle
    '{3, 1,  8, 'h31, 0, 'h32, 0, 5'b00001, 'h31, 0, 1, 0, 0, BUS_ALU,  1, BUS_LOAD},
    '{3, 0,  0, 'h00, 0, 'h00, 0, 5'b01000, 'h32, 0, 0, 0, 0, DISP,     0, DISP},
    '{3, 1,  9, 'h33, 0, 'h00, 1, 5'b00100, 'h33, 0, 1, 0, 0, BUS_DIV,  0, DISP},
    '{3, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{3, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{3, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    // ready inst stuck behind a waiting head, then two-bus collisions
    '{4, 1, 10, 'h41, 0, 'h00, 1, 5'b00000, 'h00, 0, 1, 0, 4, BUS_MUL,  0, DISP},
    '{4, 1, 11, 'h00, 1, 'h00, 1, 5'b00000, 'h00, 0, 1, 0, 0, DISP,     0, DISP},
    '{4, 1, 12, 'h42, 0, 'h42, 0, 5'b00000, 'h00, 0, 1, 0, 3, BUS_LOAD, 3, BUS_LOAD},
    '{4, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{4, 0,  0, 'h00, 0, 'h00, 0, 5'b00110, 'h41, 0, 0, 0, 0, DISP,     0, DISP},
    '{4, 0,  0, 'h00, 0, 'h00, 0, 5'b11000, 'h42, 0, 0, 0, 0, DISP,     0, DISP},
    '{4, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{4, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{4, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{4, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    // 13 waits, 14 queued behind it, 15 dispatched with the flush
    '{5, 1, 13, 'h51, 0, 'h00, 1, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{5, 1, 14, 'h00, 1, 'h00, 1, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{5, 1, 15, 'h00, 1, 'h00, 1, 5'b00000, 'h00, 1, 0, 0, 0, DISP,     0, DISP},
    '{5, 0,  0, 'h00, 0, 'h00, 0, 5'b00001, 'h51, 0, 0, 0, 0, DISP,     0, DISP},
    '{5, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{5, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{5, 1, 16, 'h00, 1, 'h00, 1, 5'b00000, 'h00, 0, 1, 0, 0, DISP,     0, DISP},
    '{5, 1, 17, 'h52, 0, 'h00, 1, 5'b00000, 'h00, 0, 1, 0, 1, BUS_MUL,  0, DISP},
    '{5, 0,  0, 'h00, 0, 'h00, 0, 5'b00010, 'h52, 0, 0, 0, 0, DISP,     0, DISP},
    '{5, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{5, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP},
    '{5, 0,  0, 'h00, 0, 'h00, 0, 5'b00000, 'h00, 0, 0, 0, 0, DISP,     0, DISP}
};

`endif

// ==== tests/br_rs_tb.sv ====
`timescale 1ns/100ps

module br_rs_tb;

    import br_rs_pkg::*;

    localparam int PERIOD       = 40;
    localparam int RST_CYCLES   = 4;
    localparam int DRAIN_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    localparam int DISP         = -1; // operand keeps its dispatched data

    // one table row is one cycle of stimulus
    typedef struct packed {
        int         test;
        int         disp;
        int         inst;
        int         t1;
        int         r1;
        int         t2;
        int         r2;
        logic [4:0] bus;  // valid mask, bit i drives bus i
        int         btag; // same tag on every active bus
        int         flush;
        int         exp;
        int         lat;
        int         o1;   // rows from dispatch to the bus that feeds op1
        int         b1;
        int         o2;
        int         b2;
    } step_t;

    `include "br_rs_cases.svh"

    localparam int WATCHDOG_CYCLES = RST_CYCLES + NUM_STEPS + 2 * DRAIN_CYCLES;

    logic        clk = 1'b0;
    logic        rst;
    logic        flush;
    logic        dispatch_valid;
    rs_entry_t   dispatch_entry;
    result_bus_t result_buses [NUM_RESULT_BUSES];
    logic        issue_valid;
    issue_t      issue_pkt;

    logic [31:0] lfsr = 32'h81adc946;
    logic [31:0] rnd [NUM_STEPS][9]; // src1, src2, pc, imm, one word per bus

    issue_t exp_q [$];
    int     due_q [$]; // -1 when latency is free
    int     cyc        = 0;
    int     test_err   = 0;
    int     err_total  = 0;
    int     pass_tests = 0;
    int     fail_tests = 0;
    string  test_names [NUM_TESTS] = '{"after reset", "ready at dispatch", "wakeup per bus",
                                       "bypass at dispatch", "in-order issue", "flush"};

    br_rs_top i_br_rs_top (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .result_buses   (result_buses),
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic fill_random();
        logic [31:0] w;
        for (int r = 0; r < NUM_STEPS; r++) begin
            for (int k = 0; k < 9; k++) begin
                for (int b = 0; b < 32; b++) begin
                    lfsr = lfsr_next(lfsr);
                    w[b] = lfsr[0]; // one step per bit
                end
                rnd[r][k] = w;
            end
        end
    endtask

    function automatic logic [31:0] source_data(int r, int off, int bus, int src);
        if (bus == DISP) return rnd[r][src];
        return rnd[r + off][4 + bus];
    endfunction

    function automatic rs_entry_t make_entry(int r);
        rs_entry_t   e;
        logic [31:0] n;
        n            = STEPS[r].inst;
        e.inst_num   = n;
        e.pc         = rnd[r][2];
        e.rd         = n[TAG_W-1:0];
        e.jump       = n[0];
        e.branch     = ~n[0];
        e.funct3     = n[2:0];
        e.imm        = rnd[r][3];
        e.pred_taken = n[1];
        e.pred_hit   = n[2];
        e.src1.tag   = STEPS[r].t1[TAG_W-1:0];
        e.src1.ready = STEPS[r].r1[0];
        e.src1.data  = rnd[r][0];
        e.src2.tag   = STEPS[r].t2[TAG_W-1:0];
        e.src2.ready = STEPS[r].r2[0];
        e.src2.data  = rnd[r][1];
        return e;
    endfunction

    function automatic issue_t expected_pkt(int r);
        rs_entry_t e;
        issue_t    p;
        e            = make_entry(r);
        p.inst_num   = e.inst_num;
        p.pc         = e.pc;
        p.rd         = e.rd;
        p.jump       = e.jump;
        p.branch     = e.branch;
        p.funct3     = e.funct3;
        p.imm        = e.imm;
        p.pred_taken = e.pred_taken;
        p.pred_hit   = e.pred_hit;
        p.op1        = source_data(r, STEPS[r].o1, STEPS[r].b1, 0);
        p.op2        = source_data(r, STEPS[r].o2, STEPS[r].b2, 1);
        return p;
    endfunction

    task automatic drive_idle();
        dispatch_valid = 1'b0;
        dispatch_entry = '0;
        flush          = 1'b0;
        for (int b = 0; b < NUM_RESULT_BUSES; b++) begin
            result_buses[b] = '0;
        end
    endtask

    task automatic apply_step(int r);
        dispatch_valid = STEPS[r].disp[0];
        dispatch_entry = STEPS[r].disp[0] ? make_entry(r) : '0;
        flush          = STEPS[r].flush[0];
        for (int b = 0; b < NUM_RESULT_BUSES; b++) begin
            result_buses[b].valid = STEPS[r].bus[b];
            result_buses[b].tag   = STEPS[r].btag[TAG_W-1:0];
            result_buses[b].data  = rnd[r][4 + b];
        end
        if (STEPS[r].disp[0] && STEPS[r].exp[0]) begin
            exp_q.push_back(expected_pkt(r));
            due_q.push_back(STEPS[r].lat[0] ? cyc + 3 : -1); // strobe edge plus two
        end
    endtask

    task automatic log_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        test_err++;
        err_total++;
    endtask

    task automatic report_test(int t);
        if (test_err == 0) begin
            pass_tests++;
            $display("test %0d %s: ok", t, test_names[t]);
        end else begin
            fail_tests++;
            $display("test %0d %s: %0d errors", t, test_names[t], test_err);
        end
        test_err = 0;
    endtask

    // in-order scoreboard
    always @(posedge clk) begin
        issue_t want;
        int     due;
        if (!rst) begin
            if (issue_valid) begin
                assert (exp_q.size() > 0)
                else log_error($sformatf("unexpected issue of inst %0d", issue_pkt.inst_num));
                if (exp_q.size() > 0) begin
                    want = exp_q.pop_front();
                    due  = due_q.pop_front();
                    assert (issue_pkt == want)
                    else log_error($sformatf("expected inst %0d op1 %h op2 %h, got inst %0d op1 %h op2 %h",
                        want.inst_num, want.op1, want.op2,
                        issue_pkt.inst_num, issue_pkt.op1, issue_pkt.op2));
                    assert (due < 0 || cyc == due)
                    else log_error($sformatf("inst %0d issued at cycle %0d, due at %0d",
                        issue_pkt.inst_num, cyc, due));
                end
            end else begin
                assert (issue_pkt == '0)
                else log_error("issue_pkt not zero while issue_valid is low");
            end
        end
        cyc++;
    end

    initial begin
        rst = 1'b1;
        drive_idle();
        fill_random();
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < NUM_STEPS; r++) begin
            if (r > 0 && STEPS[r].test != STEPS[r - 1].test) report_test(STEPS[r - 1].test);
            apply_step(r);
            @(negedge clk);
        end
        drive_idle();
        for (int i = 0; i < DRAIN_CYCLES && exp_q.size() > 0; i++) @(negedge clk);
        while (exp_q.size() > 0) begin
            $display("expected issue of inst %0d never happened", exp_q[0].inst_num);
            test_err++;
            err_total++;
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
        report_test(STEPS[NUM_STEPS - 1].test);
        $display("summary: %0d tests ok, %0d tests failed", pass_tests, fail_tests);
        if (fail_tests == 0 && err_total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== br_rs.f ====
+incdir+tests
hw/br_rs_pkg.sv
hw/br_rs_wakeup.sv
hw/br_rs_dispatch.sv
hw/br_rs_queue.sv
hw/br_rs_top.sv
tests/br_rs_tb.sv

// ==== Makefile ====
# Verilator flow for the branch reservation station
VERILATOR ?= verilator
TOP       ?= br_rs_tb
FILELIST  ?= br_rs.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
